//--- vlog.f
hdl/axil_pkg.sv
hdl/hw_regmap_pkg.sv
hdl/axil_slave_fsm.sv
hdl/hw_regs.sv
hdl/tick_counter.sv
hdl/hello_world_top.sv
sim/hello_world_sva.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top \
  -Mdir obj_dir -o tb_top_sim -f vlog.f

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "Simulation failed"
  exit 1
fi
grep -q '>>> PASS' sim.log
echo "Simulation passed"

//--- sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int WAIT_LIMIT = 50;
  localparam int VLED_LIMIT = 4;

  logic                clk_main_a0;
  logic                rst_main_n_sync;
  axil_pkg::axil_req_t req;
  axil_pkg::axil_rsp_t rsp;
  logic [15:0]         vdip;
  logic [15:0]         vled;
  logic                exp_on;
  logic [31:0]         exp_rdata;
  logic                vled_check;
  logic [15:0]         exp_vled;
  int                  err_count;
  int                  check_count;
  int                  tb_errs;
  int                  errs_mark;
  logic [31:0]         lfsr;

  // Register model
  logic [31:0] m_hello;
  logic        m_enable;
  logic        m_oneshot;
  logic [7:0]  m_tick;
  logic [15:0] m_load;
  logic [15:0] m_wmark;
  logic [15:0] m_count;

  hello_world_top #(
    .CNT_W  (16),
    .TICK_W (8)
  ) dut0 (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (req),
    .rsp             (rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  tb_checker u_checker (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (req),
    .rsp             (rsp),
    .vled            (vled),
    .exp_on          (exp_on),
    .exp_rdata       (exp_rdata),
    .vled_check      (vled_check),
    .exp_vled        (exp_vled),
    .err_count       (err_count),
    .check_count     (check_count)
  );

  always #2 clk_main_a0 = ~clk_main_a0;

  // ------------------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------------------
  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [31:0] v;
    case (addr)
      hw_regmap_pkg::HELLO_WORLD_ADDR:
        v = {m_hello[7:0], m_hello[15:8], m_hello[23:16], m_hello[31:24]};
      hw_regmap_pkg::VLED_ADDR:      v = {16'h0000, m_hello[15:0]};
      // Clear bit always reads back as zero
      hw_regmap_pkg::CNT_CTRL_ADDR:  v = {16'h0000, m_tick, 6'b000000, m_oneshot, m_enable};
      hw_regmap_pkg::CNT_LOAD_ADDR:  v = {16'h0000, m_load};
      hw_regmap_pkg::CNT_WMARK_ADDR: v = {16'h0000, m_wmark};
      hw_regmap_pkg::CNT_STAT_ADDR:  v = {15'h0000, m_count >= m_wmark, m_count};
      default:                       v = hw_regmap_pkg::UNIMPL_VALUE;
    endcase
    return v;
  endfunction

  // Count only tracks writes while the counter is disabled
  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      hw_regmap_pkg::HELLO_WORLD_ADDR: m_hello = data;
      hw_regmap_pkg::CNT_CTRL_ADDR: begin
        m_enable  = data[0];
        m_oneshot = data[1];
        m_tick    = data[15:8];
        if (data[2]) begin
          m_count = '0;
        end
      end
      hw_regmap_pkg::CNT_LOAD_ADDR: begin
        m_load  = data[15:0];
        m_count = data[15:0];
      end
      hw_regmap_pkg::CNT_WMARK_ADDR: m_wmark = data[15:0];
      default: ;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Bus driver, handshakes observed at the falling edge
  // ------------------------------------------------------------------------
  task automatic note_timeout(input int n, input string what);
    if (n >= WAIT_LIMIT) begin
      $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
      tb_errs++;
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(negedge clk_main_a0);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hF;
    req.bready  = 1'b0;
    n = 0;
    while (!rsp.awready && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    note_timeout(n, "awready");
    @(negedge clk_main_a0);
    req.awvalid = 1'b0;
    n = 0;
    while (!rsp.wready && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    note_timeout(n, "wready");
    @(negedge clk_main_a0);
    req.wvalid = 1'b0;
    n = 0;
    while (!rsp.bvalid && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    note_timeout(n, "bvalid");
    if (n > 0 && n < WAIT_LIMIT) begin
      $display("Write at %0t ns: bvalid came %0d cycles late", $time, n);
      tb_errs++;
    end
    // Response stalled for one edge, then taken
    @(negedge clk_main_a0);
    req.bready = 1'b1;
    @(negedge clk_main_a0);
    req.bready = 1'b0;
    model_write(addr, data);
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic check, input int hold,
                           output logic [31:0] data);
    int n;
    @(negedge clk_main_a0);
    exp_on      = check;
    exp_rdata   = ref_read(addr);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b0;
    n = 0;
    while (!rsp.arready && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    note_timeout(n, "arready");
    @(negedge clk_main_a0);
    req.arvalid = 1'b0;
    n = 0;
    while (!rsp.rvalid && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    note_timeout(n, "rvalid");
    if (n != 1 && n < WAIT_LIMIT) begin
      $display("Read at %0t ns: rvalid did not come 2 cycles after accept", $time);
      tb_errs++;
    end
    // Back-pressure before taking the data
    repeat (hold) @(negedge clk_main_a0);
    req.rready = 1'b1;
    data = rsp.rdata;
    @(negedge clk_main_a0);
    req.rready = 1'b0;
  endtask

  task automatic wait_vled();
    int n;
    logic [15:0] want;
    want = m_hello[15:0] & vdip;
    n = 0;
    while (vled !== want && n < VLED_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    if (vled !== want) begin
      $display("Timeout at %0t ns: vled did not settle within %0d cycles", $time, VLED_LIMIT);
    end
    exp_vled   = want;
    vled_check = 1'b1;
    @(negedge clk_main_a0);
    vled_check = 1'b0;
  endtask

  task automatic end_test(input string name);
    int total;
    total = err_count + tb_errs;
    if (total == errs_mark) begin
      $display("Test %-24s ok", name);
    end else begin
      $display("Test %-24s %0d errors", name, total - errs_mark);
    end
    errs_mark = total;
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] d;
    logic [31:0] a;
    logic [31:0] r;
    int n;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    req             = '0;
    vdip            = '0;
    exp_on          = 1'b0;
    exp_rdata       = '0;
    vled_check      = 1'b0;
    exp_vled        = '0;
    tb_errs         = 0;
    errs_mark       = 0;
    lfsr            = 32'd38;
    m_hello         = '0;
    m_enable        = 1'b0;
    m_oneshot       = 1'b0;
    m_tick          = '0;
    m_load          = '0;
    m_wmark         = '0;
    m_count         = '0;
    repeat (3) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    for (int i = 0; i < 4; i++) begin
      rand_bits(32, d);
      axil_write(hw_regmap_pkg::HELLO_WORLD_ADDR, d);
      axil_read(hw_regmap_pkg::HELLO_WORLD_ADDR, 1'b1, 0, r);
    end
    end_test("hello-world swap");

    rand_bits(32, d);
    axil_write(hw_regmap_pkg::HELLO_WORLD_ADDR, d);
    axil_read(hw_regmap_pkg::VLED_ADDR, 1'b1, 0, r);
    for (int i = 0; i < 4; i++) begin
      rand_bits(16, d);
      @(negedge clk_main_a0);
      vdip = d[15:0];
      wait_vled();
    end
    end_test("virtual LEDs");

    for (int i = 0; i < 3; i++) begin
      // Word addresses from 0x1000 up, clear of the map
      rand_bits(12, a);
      a = {a[31:2], 2'b00} + 32'h0000_1000;
      axil_read(a, 1'b1, 0, r);
      rand_bits(32, d);
      axil_write(a, d);
    end
    axil_read(hw_regmap_pkg::HELLO_WORLD_ADDR, 1'b1, 0, r);
    axil_read(hw_regmap_pkg::VLED_ADDR, 1'b1, 0, r);
    axil_read(hw_regmap_pkg::CNT_CTRL_ADDR, 1'b1, 0, r);
    axil_read(hw_regmap_pkg::CNT_LOAD_ADDR, 1'b1, 0, r);
    axil_read(hw_regmap_pkg::CNT_WMARK_ADDR, 1'b1, 0, r);
    end_test("unimplemented addresses");

    axil_write(hw_regmap_pkg::CNT_CTRL_ADDR, 32'h0000_0000);
    for (int i = 0; i < 3; i++) begin
      rand_bits(16, d);
      axil_write(hw_regmap_pkg::CNT_WMARK_ADDR, d);
      rand_bits(16, d);
      axil_write(hw_regmap_pkg::CNT_LOAD_ADDR, d);
      axil_read(hw_regmap_pkg::CNT_STAT_ADDR, 1'b1, 0, r);
      axil_read(hw_regmap_pkg::CNT_LOAD_ADDR, 1'b1, 0, r);
    end
    axil_write(hw_regmap_pkg::CNT_CTRL_ADDR, 32'h0000_0004);
    axil_read(hw_regmap_pkg::CNT_STAT_ADDR, 1'b1, 0, r);
    axil_read(hw_regmap_pkg::CNT_CTRL_ADDR, 1'b1, 0, r);
    end_test("counter load and clear");

    rand_bits(16, d);
    axil_write(hw_regmap_pkg::CNT_WMARK_ADDR, d);
    axil_write(hw_regmap_pkg::CNT_LOAD_ADDR, 32'h0000_FFF0);
    // Enable and one-shot, tick value 0
    axil_write(hw_regmap_pkg::CNT_CTRL_ADDR, 32'h0000_0003);
    n = 0;
    r = '0;
    while (r[15:0] != 16'hFFFF && n < WAIT_LIMIT) begin
      axil_read(hw_regmap_pkg::CNT_STAT_ADDR, 1'b0, 0, r);
      n++;
    end
    if (r[15:0] != 16'hFFFF) begin
      $display("Timeout at %0t ns: counter never reached 0xffff", $time);
      tb_errs++;
    end
    m_count = 16'hFFFF;
    for (int i = 0; i < 4; i++) begin
      axil_read(hw_regmap_pkg::CNT_STAT_ADDR, 1'b1, 0, r);
    end
    end_test("one-shot saturation");

    axil_write(hw_regmap_pkg::CNT_CTRL_ADDR, 32'h0000_0000);
    for (int i = 0; i < 3; i++) begin
      rand_bits(3, d);
      axil_read(hw_regmap_pkg::HELLO_WORLD_ADDR, 1'b1, int'(d) + 1, r);
      rand_bits(3, d);
      axil_read(hw_regmap_pkg::CNT_STAT_ADDR, 1'b1, int'(d) + 1, r);
    end
    end_test("read back-pressure");

    $display("Done: %0d checks, %0d errors", check_count, err_count + tb_errs);
    if (err_count + tb_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
  input  logic                clk_main_a0,
  input  logic                rst_main_n_sync,
  input  axil_pkg::axil_req_t req,
  input  axil_pkg::axil_rsp_t rsp,
  input  logic [15:0]         vled,
  input  logic                exp_on,
  input  logic [31:0]         exp_rdata,
  input  logic                vled_check,
  input  logic [15:0]         exp_vled,
  output int                  err_count,
  output int                  check_count
);

  logic        hold_armed;
  logic [31:0] held_rdata;

  // Inputs change on the falling edge, so the rising edge sees them settled
  always @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      err_count   = 0;
      check_count = 0;
      hold_armed  = 1'b0;
      held_rdata  = '0;
    end else begin
      // Completed read
      if (rsp.rvalid && req.rready && exp_on) begin
        check_count = check_count + 1;
        if (rsp.rdata !== exp_rdata) begin
          $display("FAILED at %0t ns: rdata = %h, expected %h", $time, rsp.rdata, exp_rdata);
          err_count = err_count + 1;
        end
      end
      if (rsp.rvalid && req.rready) begin
        check_count = check_count + 1;
        if (rsp.rresp !== axil_pkg::RESP_OKAY) begin
          $display("FAILED at %0t ns: rresp = %b, expected %b",
                   $time, rsp.rresp, axil_pkg::RESP_OKAY);
          err_count = err_count + 1;
        end
      end
      // Completed write response
      if (rsp.bvalid && req.bready) begin
        check_count = check_count + 1;
        if (rsp.bresp !== axil_pkg::RESP_OKAY) begin
          $display("FAILED at %0t ns: bresp = %b, expected %b",
                   $time, rsp.bresp, axil_pkg::RESP_OKAY);
          err_count = err_count + 1;
        end
      end
      // rdata must hold while the master stalls
      if (hold_armed && rsp.rvalid) begin
        check_count = check_count + 1;
        if (rsp.rdata !== held_rdata) begin
          $display("FAILED at %0t ns: rdata = %h under back-pressure, expected %h",
                   $time, rsp.rdata, held_rdata);
          err_count = err_count + 1;
        end
      end
      hold_armed = rsp.rvalid && !req.rready;
      held_rdata = rsp.rdata;

      if (vled_check) begin
        check_count = check_count + 1;
        if (vled !== exp_vled) begin
          $display("FAILED at %0t ns: vled = %h, expected %h", $time, vled, exp_vled);
          err_count = err_count + 1;
        end
      end
    end
  end

endmodule

//--- sim/hello_world_sva.sv
`timescale 1ns/1ns

module hello_world_sva (
  input logic                clk_main_a0,
  input logic                rst_main_n_sync,
  input axil_pkg::axil_req_t req,
  input axil_pkg::axil_rsp_t rsp
);

  // Read response and its data hold until taken
  rvalid_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata)
  ) else $error("rvalid dropped or rdata changed before rready");

  bvalid_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.bvalid && !req.bready |=> rsp.bvalid
  ) else $error("bvalid dropped before bready");

  arready_low: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.rvalid |-> !rsp.arready
  ) else $error("arready high while rvalid pending");

  // Both address channels open right out of reset
  ready_after_reset: assert property (
    @(posedge clk_main_a0)
    $rose(rst_main_n_sync) |-> rsp.awready && rsp.arready
  ) else $error("awready or arready low after reset");

endmodule

bind hello_world_top hello_world_sva u_sva (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .req             (req),
  .rsp             (rsp)
);

//--- hdl/hello_world_top.sv
`timescale 1ns/1ns

module hello_world_top #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic                clk_main_a0,
  input  logic                rst_main_n_sync,
  input  axil_pkg::axil_req_t req,
  output axil_pkg::axil_rsp_t rsp,
  input  logic [15:0]         vdip,
  output logic [15:0]         vled
);

  logic                             wr_en;
  logic [axil_pkg::AXIL_ADDR_W-1:0] wr_addr;
  logic [axil_pkg::AXIL_DATA_W-1:0] wr_data;
  logic                             rd_en;
  logic [axil_pkg::AXIL_ADDR_W-1:0] rd_addr;
  logic [axil_pkg::AXIL_DATA_W-1:0] rd_data;
  hw_regmap_pkg::cnt_ctrl_t         cnt_ctrl;
  hw_regmap_pkg::cnt_stat_t         cnt_stat;

  // Bus protocol engine
  axil_slave_fsm u_axil_slave_fsm (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (req),
    .rsp             (rsp),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  hw_regs #(
    .CNT_W  (CNT_W),
    .TICK_W (TICK_W)
  ) u_hw_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vdip            (vdip),
    .vled            (vled),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_stat        (cnt_stat)
  );

  // Counter steered by the CNT_* registers
  tick_counter #(
    .CNT_W  (CNT_W),
    .TICK_W (TICK_W)
  ) u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ctrl            (cnt_ctrl),
    .stat            (cnt_stat)
  );

endmodule

//--- hdl/tick_counter.sv
`timescale 1ns/1ns

module tick_counter #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  hw_regmap_pkg::cnt_ctrl_t ctrl,
  output hw_regmap_pkg::cnt_stat_t stat
);

  logic [TICK_W-1:0] tick_cnt_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              tick_q;
  logic              ge_q;
  logic              tick_hit;
  logic              cnt_full;

  // Prescaler wraps once it reaches the programmed tick value
  assign tick_hit = (tick_cnt_q >= ctrl.tick_value);
  assign cnt_full = (cnt_q == {CNT_W{1'b1}});

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
      cnt_q      <= '0;
    end else begin
      if (ctrl.clear) begin
        tick_cnt_q <= '0;
      end else if (ctrl.enable) begin
        tick_cnt_q <= tick_hit ? '0 : tick_cnt_q + 1'b1;
      end

      // Clear wins over load, load over counting
      if (ctrl.clear) begin
        cnt_q <= '0;
      end else if (ctrl.load) begin
        cnt_q <= ctrl.load_value;
      end else if (ctrl.enable && tick_hit && !(ctrl.oneshot && cnt_full)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Status flags, one cycle behind the count
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_q <= 1'b0;
      ge_q   <= 1'b0;
    end else begin
      tick_q <= ctrl.enable & tick_hit;
      ge_q   <= (cnt_q >= ctrl.watermark);
    end
  end

  assign stat.tick         = tick_q;
  assign stat.ge_watermark = ge_q;
  assign stat.count        = cnt_q;

endmodule

//--- hdl/hw_regs.sv
`timescale 1ns/1ns

module hw_regs #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  input  logic                      wr_en,
  input  logic [31:0]               wr_addr,
  input  logic [31:0]               wr_data,
  input  logic                      rd_en,
  input  logic [31:0]               rd_addr,
  output logic [31:0]               rd_data,
  input  logic [15:0]               vdip,
  output logic [15:0]               vled,
  output hw_regmap_pkg::cnt_ctrl_t  cnt_ctrl,
  input  hw_regmap_pkg::cnt_stat_t  cnt_stat
);

  logic [31:0]       hello_world_q;
  logic [31:0]       hello_world_swapped;
  logic              cnt_enable_q;
  logic              cnt_oneshot_q;
  logic [TICK_W-1:0] tick_value_q;
  logic [CNT_W-1:0]  load_value_q;
  logic [CNT_W-1:0]  watermark_q;
  logic              clear_pulse_q;
  logic              load_pulse_q;
  logic [15:0]       vled_q;
  logic [15:0]       vdip_q;
  logic [15:0]       vdip_q2;
  logic [31:0]       ctrl_word;
  logic [31:0]       stat_word;

  // --------------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
      cnt_enable_q  <= 1'b0;
      cnt_oneshot_q <= 1'b0;
      tick_value_q  <= '0;
      load_value_q  <= '0;
      watermark_q   <= '0;
      clear_pulse_q <= 1'b0;
      load_pulse_q  <= 1'b0;
    end else begin
      clear_pulse_q <= 1'b0;
      load_pulse_q  <= 1'b0;
      if (wr_en) begin
        case (wr_addr)
          hw_regmap_pkg::HELLO_WORLD_ADDR: hello_world_q <= wr_data;
          hw_regmap_pkg::CNT_CTRL_ADDR: begin
            cnt_enable_q  <= wr_data[hw_regmap_pkg::CTRL_ENABLE_BIT];
            cnt_oneshot_q <= wr_data[hw_regmap_pkg::CTRL_ONESHOT_BIT];
            tick_value_q  <= wr_data[hw_regmap_pkg::CTRL_TICK_LSB +: TICK_W];
            // Clear is a command, never stored
            clear_pulse_q <= wr_data[hw_regmap_pkg::CTRL_CLEAR_BIT];
          end
          hw_regmap_pkg::CNT_LOAD_ADDR: begin
            load_value_q <= wr_data[CNT_W-1:0];
            load_pulse_q <= 1'b1;
          end
          hw_regmap_pkg::CNT_WMARK_ADDR: watermark_q <= wr_data[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign cnt_ctrl.enable     = cnt_enable_q;
  assign cnt_ctrl.oneshot    = cnt_oneshot_q;
  assign cnt_ctrl.clear      = clear_pulse_q;
  assign cnt_ctrl.load       = load_pulse_q;
  assign cnt_ctrl.tick_value = tick_value_q;
  assign cnt_ctrl.load_value = load_value_q;
  assign cnt_ctrl.watermark  = watermark_q;

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------
  assign hello_world_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                                hello_world_q[23:16], hello_world_q[31:24]};

  always_comb begin
    ctrl_word = '0;
    ctrl_word[hw_regmap_pkg::CTRL_ENABLE_BIT]  = cnt_enable_q;
    ctrl_word[hw_regmap_pkg::CTRL_ONESHOT_BIT] = cnt_oneshot_q;
    ctrl_word[hw_regmap_pkg::CTRL_TICK_LSB +: TICK_W] = tick_value_q;
    stat_word = '0;
    stat_word[CNT_W-1:0] = cnt_stat.count;
    stat_word[hw_regmap_pkg::STAT_GE_BIT] = cnt_stat.ge_watermark;
  end

  always_comb begin
    rd_data = '0;
    if (rd_en) begin
      case (rd_addr)
        hw_regmap_pkg::HELLO_WORLD_ADDR: rd_data = hello_world_swapped;
        hw_regmap_pkg::VLED_ADDR:        rd_data = {16'h0000, vled_q};
        hw_regmap_pkg::CNT_CTRL_ADDR:    rd_data = ctrl_word;
        hw_regmap_pkg::CNT_LOAD_ADDR:    rd_data = 32'(load_value_q);
        hw_regmap_pkg::CNT_WMARK_ADDR:   rd_data = 32'(watermark_q);
        hw_regmap_pkg::CNT_STAT_ADDR:    rd_data = stat_word;
        default:                         rd_data = hw_regmap_pkg::UNIMPL_VALUE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Virtual LEDs
  // --------------------------------------------------------------------------
  // Shadow of hello-world low half, masked by synchronised DIP switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q  <= '0;
      vdip_q  <= '0;
      vdip_q2 <= '0;
      vled    <= '0;
    end else begin
      vled_q  <= hello_world_q[15:0];
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
      vled    <= vled_q & vdip_q2;
    end
  end

endmodule

//--- hdl/axil_slave_fsm.sv
`timescale 1ns/1ns

module axil_slave_fsm (
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  input  axil_pkg::axil_req_t              req,
  output axil_pkg::axil_rsp_t              rsp,
  output logic                             wr_en,
  output logic [axil_pkg::AXIL_ADDR_W-1:0] wr_addr,
  output logic [axil_pkg::AXIL_DATA_W-1:0] wr_data,
  output logic                             rd_en,
  output logic [axil_pkg::AXIL_ADDR_W-1:0] rd_addr,
  input  logic [axil_pkg::AXIL_DATA_W-1:0] rd_data
);

  logic                             wr_active_q;
  logic [axil_pkg::AXIL_ADDR_W-1:0] wr_addr_q;
  logic                             bvalid_q;
  logic                             aw_hs;
  logic                             wready;
  logic                             ar_acc_q;
  logic [axil_pkg::AXIL_ADDR_W-1:0] rd_addr_q;
  logic                             rvalid_q;
  logic [axil_pkg::AXIL_DATA_W-1:0] rdata_q;
  logic                             arready;
  logic                             ar_hs;

  // --------------------------------------------------------------------------
  // Write channel
  // --------------------------------------------------------------------------
  assign aw_hs  = req.awvalid & ~wr_active_q;
  // Data phase closes once the response is pending
  assign wready = wr_active_q & ~bvalid_q & req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active_q <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      if (aw_hs) begin
        wr_active_q <= 1'b1;
      end else if (bvalid_q && req.bready) begin
        wr_active_q <= 1'b0;
      end
      if (wready) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= req.awaddr;
    end
  end

  // --------------------------------------------------------------------------
  // Read channel
  // --------------------------------------------------------------------------
  assign arready = ~ar_acc_q & ~rvalid_q;
  assign ar_hs   = req.arvalid & arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_acc_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      ar_acc_q <= ar_hs;
      if (ar_acc_q) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Address and data hold until the next accept
  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= req.araddr;
    end
    if (ar_acc_q) begin
      rdata_q <= rd_data;
    end
  end

  // Register side strobes
  assign wr_en   = wready;
  assign wr_addr = wr_addr_q;
  assign wr_data = req.wdata;
  assign rd_en   = ar_acc_q;
  assign rd_addr = rd_addr_q;

  always_comb begin
    rsp         = '0;
    rsp.awready = ~wr_active_q;
    rsp.wready  = wready;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = axil_pkg::RESP_OKAY;
    rsp.arready = arready;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = axil_pkg::RESP_OKAY;
  end

endmodule

//--- hdl/hw_regmap_pkg.sv
package hw_regmap_pkg;

  // Register addresses
  localparam logic [31:0] HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam logic [31:0] VLED_ADDR        = 32'h0000_0504;
  localparam logic [31:0] CNT_CTRL_ADDR    = 32'h0000_0508;
  localparam logic [31:0] CNT_LOAD_ADDR    = 32'h0000_050C;
  localparam logic [31:0] CNT_WMARK_ADDR   = 32'h0000_0510;
  localparam logic [31:0] CNT_STAT_ADDR    = 32'h0000_0514;

  // Returned for any address outside the map
  localparam logic [31:0] UNIMPL_VALUE = 32'hDEAD_BEEF;

  // CNT_CTRL fields, tick value sits in bits 15:8
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;
  localparam int CTRL_TICK_LSB    = 8;

  // CNT_STAT watermark flag
  localparam int STAT_GE_BIT = 16;

  // Counter control, clear and load are single-cycle pulses
  typedef struct packed {
    logic        enable;
    logic        oneshot;
    logic        clear;
    logic        load;
    logic [7:0]  tick_value;
    logic [15:0] load_value;
    logic [15:0] watermark;
  } cnt_ctrl_t;

  typedef struct packed {
    logic        tick;
    logic        ge_watermark;
    logic [15:0] count;
  } cnt_stat_t;

endpackage

//--- hdl/axil_pkg.sv
package axil_pkg;

  // Bus widths
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // Response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Master to slave
  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage
